//--- logic/decode_pkg.sv
package decode_pkg;

    // Widths fixed by the RV32I ISA
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    // Machine status, scratch and the read-only cycle counter
    localparam logic [csr_addr_w-1:0] csr_status_addr  = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_scratch_addr = 12'h340;
    localparam logic [csr_addr_w-1:0] csr_cycle_addr   = 12'hC00;

    // funct3 codes of the two supported SYSTEM instructions
    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrwi = 3'b101;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_t;

    // imm_csr carries the 12-bit CSR address from bits 31:20
    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j,
        imm_csr
    } imm_type_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc_plus4,
        res_csr
    } result_src_t;

endpackage

//--- logic/control_unit.sv
`timescale 1ns/1ps

module control_unit import decode_pkg::*; (
    input  opcode_t     opcode,
    input  logic [2:0]  funct3,
    input  logic        funct7_5,
    output imm_type_t   imm_type,
    output alu_op_t     alu_op,
    output logic        alu_src,
    output result_src_t result_src,
    output logic        reg_write,
    output logic        mem_write,
    output logic        branch,
    output logic        jump,
    output logic        csr_write,
    output logic        csr_imm,
    output logic        illegal
);
    alu_op_t alu_f3;

    // funct7 bit 5 picks SUB only for register ops, SRA for both register and immediate shifts
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (opcode == opc_op && funct7_5) ? alu_sub : alu_add;
            3'b001:  alu_f3 = alu_sll;
            3'b010:  alu_f3 = alu_slt;
            3'b011:  alu_f3 = alu_sltu;
            3'b100:  alu_f3 = alu_xor;
            3'b101:  alu_f3 = funct7_5 ? alu_sra : alu_srl;
            3'b110:  alu_f3 = alu_or;
            default: alu_f3 = alu_and;
        endcase
    end

    always_comb begin
        imm_type   = imm_i;
        alu_op     = alu_add;
        alu_src    = 1'b0;
        result_src = res_alu;
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        csr_write  = 1'b0;
        csr_imm    = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            opc_lui, opc_auipc: begin
                imm_type  = imm_u;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            opc_jal: begin
                imm_type   = imm_j;
                result_src = res_pc_plus4;
                reg_write  = 1'b1;
                jump       = 1'b1;
            end
            opc_jalr: begin
                alu_src    = 1'b1;
                result_src = res_pc_plus4;
                reg_write  = 1'b1;
                jump       = 1'b1;
            end
            opc_branch: begin
                imm_type = imm_b;
                alu_op   = alu_sub;
                branch   = 1'b1;
            end
            opc_load: begin
                alu_src    = 1'b1;
                result_src = res_mem;
                reg_write  = 1'b1;
            end
            opc_store: begin
                imm_type  = imm_s;
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            opc_op_imm: begin
                alu_op    = alu_f3;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            opc_op: begin
                alu_op    = alu_f3;
                reg_write = 1'b1;
            end
            opc_system: begin
                imm_type = imm_csr;
                if (funct3 == f3_csrrw || funct3 == f3_csrrwi) begin
                    result_src = res_csr;
                    reg_write  = 1'b1;
                    csr_write  = 1'b1;
                    csr_imm    = funct3[2];
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

//--- logic/imm_extend.sv
`timescale 1ns/1ps

module imm_extend import decode_pkg::*; (
    input  logic [xlen-1:0] instr,
    input  imm_type_t       imm_type,
    output logic [xlen-1:0] imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_type)
            imm_i: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            imm_s: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            // Branch offsets are in halfwords, so bit 0 is always zero
            imm_b: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            imm_u: begin
                imm = {instr[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            // CSR address, never sign-extended
            imm_csr: begin
                imm = {{(xlen - csr_addr_w){1'b0}}, instr[31:20]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] ra1,
    input  logic [reg_addr_w-1:0] ra2,
    input  logic [reg_addr_w-1:0] wa,
    input  logic [xlen-1:0]       wd,
    output logic [xlen-1:0]       rd1,
    output logic [xlen-1:0]       rd2
);
    // x0 has no storage
    logic [xlen-1:0] regs [1:31];
    logic            wr_active;

    assign wr_active = we && (wa != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_active) begin
            regs[wa] <= wd;
        end
    end

    // A read of the register being written this cycle sees the new value
    always_comb begin
        if (ra1 == '0)
            rd1 = '0;
        else if (wr_active && wa == ra1)
            rd1 = wd;
        else
            rd1 = regs[ra1];

        if (ra2 == '0)
            rd2 = '0;
        else if (wr_active && wa == ra2)
            rd2 = wd;
        else
            rd2 = regs[ra2];
    end

endmodule

//--- logic/csr_file.sv
`timescale 1ns/1ps

module csr_file import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [csr_addr_w-1:0] addr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata,
    output logic [xlen-1:0]       status
);
    logic [xlen-1:0] status_q;
    logic [xlen-1:0] scratch_q;
    logic [xlen-1:0] cycle_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_q  <= '0;
            scratch_q <= '0;
        end else if (we) begin
            case (addr)
                csr_status_addr:  status_q  <= wdata;
                csr_scratch_addr: scratch_q <= wdata;
                default: begin
                    // cycle and unknown addresses are not writable
                end
            endcase
        end
    end

    // Counts every clock, whether the pipeline is stalled or not
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    always_comb begin
        case (addr)
            csr_status_addr:  rdata = status_q;
            csr_scratch_addr: rdata = scratch_q;
            csr_cycle_addr:   rdata = cycle_q;
            default:          rdata = '0;
        endcase
    end

    assign status = status_q;

endmodule

//--- logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  instr_valid,
    input  logic [xlen-1:0]       instr,
    input  logic [xlen-1:0]       pc,
    input  logic [reg_addr_w-1:0] rd_w,
    input  logic [xlen-1:0]       result_w,
    input  logic                  reg_write_w,
    output logic                  valid_e,
    output logic [xlen-1:0]       pc_e,
    output logic [xlen-1:0]       pc_plus4_e,
    output logic [reg_addr_w-1:0] rs1_e,
    output logic [reg_addr_w-1:0] rs2_e,
    output logic [reg_addr_w-1:0] rd_e,
    output logic [xlen-1:0]       rd1_e,
    output logic [xlen-1:0]       rd2_e,
    output logic [xlen-1:0]       imm_e,
    output alu_op_t               alu_op_e,
    output logic                  alu_src_e,
    output result_src_t           result_src_e,
    output logic                  reg_write_e,
    output logic                  mem_write_e,
    output logic                  branch_e,
    output logic                  jump_e,
    output logic [xlen-1:0]       csr_rdata_e,
    output logic                  illegal_e,
    output logic [xlen-1:0]       status
);
    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic [xlen-1:0]       rd1, rd2, imm, csr_rdata, csr_wdata, pc_plus4;
    imm_type_t             imm_type;
    alu_op_t               alu_op;
    result_src_t           result_src;
    logic                  alu_src, reg_write, mem_write, branch, jump;
    logic                  csr_write, csr_imm, illegal, csr_we;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    control_unit u_control (
        .opcode(opcode_t'(instr[6:0])), .funct3(instr[14:12]), .funct7_5(instr[30]),
        .imm_type(imm_type), .alu_op(alu_op), .alu_src(alu_src), .result_src(result_src),
        .reg_write(reg_write), .mem_write(mem_write), .branch(branch), .jump(jump),
        .csr_write(csr_write), .csr_imm(csr_imm), .illegal(illegal)
    );

    imm_extend u_imm (.instr(instr), .imm_type(imm_type), .imm(imm));

    reg_file u_regs (
        .clk(clk), .reset(reset), .we(reg_write_w), .ra1(rs1), .ra2(rs2),
        .wa(rd_w), .wd(result_w), .rd1(rd1), .rd2(rd2)
    );

    // CSRRWI writes the rs1 field as a zero-extended value
    assign csr_wdata = csr_imm ? {{(xlen - reg_addr_w){1'b0}}, rs1} : rd1;
    assign csr_we    = csr_write && instr_valid && !stall && !illegal;

    csr_file u_csrs (
        .clk(clk), .reset(reset), .we(csr_we), .addr(imm[csr_addr_w-1:0]),
        .wdata(csr_wdata), .rdata(csr_rdata), .status(status)
    );

    assign pc_plus4 = pc + xlen'(4);

    // ID/EX control, enables only pass for a valid instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_e     <= 1'b0;
            reg_write_e <= 1'b0;
            mem_write_e <= 1'b0;
            branch_e    <= 1'b0;
            jump_e      <= 1'b0;
            illegal_e   <= 1'b0;
        end else if (!stall) begin
            valid_e     <= instr_valid;
            reg_write_e <= instr_valid && reg_write;
            mem_write_e <= instr_valid && mem_write;
            branch_e    <= instr_valid && branch;
            jump_e      <= instr_valid && jump;
            illegal_e   <= instr_valid && illegal;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_e         <= pc;
            pc_plus4_e   <= pc_plus4;
            rs1_e        <= rs1;
            rs2_e        <= rs2;
            rd_e         <= rd;
            rd1_e        <= rd1;
            rd2_e        <= rd2;
            imm_e        <= imm;
            alu_op_e     <= alu_op;
            alu_src_e    <= alu_src;
            result_src_e <= result_src;
            csr_rdata_e  <= csr_rdata;
        end
    end

endmodule

//--- verification/decode_checker.sv
`timescale 1ns/1ps

module decode_checker import decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [4:0]  rd_w,
    input  logic [31:0] result_w,
    input  logic        reg_write_w,
    input  logic        valid_e,
    input  logic [31:0] pc_e,
    input  logic [31:0] pc_plus4_e,
    input  logic [4:0]  rs1_e,
    input  logic [4:0]  rs2_e,
    input  logic [4:0]  rd_e,
    input  logic [31:0] rd1_e,
    input  logic [31:0] rd2_e,
    input  logic [31:0] imm_e,
    input  alu_op_t     alu_op_e,
    input  logic        alu_src_e,
    input  result_src_t result_src_e,
    input  logic        reg_write_e,
    input  logic        mem_write_e,
    input  logic        branch_e,
    input  logic        jump_e,
    input  logic        illegal_e,
    input  logic [31:0] csr_rdata_e,
    input  logic [31:0] status,
    output int          errors
);
    logic [31:0] shadow [0:31];
    logic [31:0] status_m, scratch_m;
    string       next_name, cur_name;
    logic [31:0] next_imm, cur_imm, exp_rd1, exp_rd2, exp_csr;
    logic [31:0] cur_instr, cur_pc;
    alu_op_t     next_alu, cur_alu;
    result_src_t next_res, cur_res;
    logic        next_rw, next_mw, next_ill, cur_rw, cur_mw, cur_ill;
    logic        next_src, next_br, next_jp, cur_src, cur_br, cur_jp;
    logic        cur_valid, cur_csr;
    int          err_count = 0;

    assign errors = err_count;

    // Register read as seen during decode, including a write-back in the same cycle
    function automatic logic [31:0] read_reg(input logic [4:0] a);
        if (a == 5'd0)
            return 32'd0;
        if (reg_write_w && rd_w == a)
            return result_w;
        return shadow[a];
    endfunction

    function automatic logic [31:0] read_csr(input logic [11:0] a);
        if (a == 12'h300)
            return status_m;
        if (a == 12'h340)
            return scratch_m;
        return 32'd0;
    endfunction

    task automatic set_expect(input string name, input logic [31:0] imm, input alu_op_t alu,
                              input logic src, input result_src_t res, input logic rw,
                              input logic mw, input logic br, input logic jp, input logic ill);
        next_name = name;
        next_imm  = imm;
        next_alu  = alu;
        next_src  = src;
        next_res  = res;
        next_rw   = rw;
        next_mw   = mw;
        next_br   = br;
        next_jp   = jp;
        next_ill  = ill;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_count++;
            $display("[ERROR] %s %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    always @(posedge clk) begin : model
        logic        is_csr;
        logic [11:0] csr_addr;
        logic [31:0] wdata;
        is_csr   = instr[6:0] == 7'b1110011 && (instr[14:12] == 3'b001 || instr[14:12] == 3'b101);
        csr_addr = instr[31:20];
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] = 32'd0;
            end
            status_m  = 32'd0;
            scratch_m = 32'd0;
            cur_valid = 1'b0;
        end else begin
            if (!stall) begin
                cur_valid = instr_valid;
                cur_name  = next_name;
                cur_instr = instr;
                cur_pc    = pc;
                cur_imm   = next_imm;
                cur_alu   = next_alu;
                cur_src   = next_src;
                cur_res   = next_res;
                cur_rw    = next_rw;
                cur_mw    = next_mw;
                cur_br    = next_br;
                cur_jp    = next_jp;
                cur_ill   = next_ill;
                cur_csr   = is_csr;
                exp_rd1   = read_reg(instr[19:15]);
                exp_rd2   = read_reg(instr[24:20]);
                exp_csr   = read_csr(csr_addr);
                // CSRRWI takes the rs1 field itself, CSRRW the register value
                if (instr_valid && is_csr) begin
                    wdata = instr[14] ? {27'd0, instr[19:15]} : exp_rd1;
                    if (csr_addr == 12'h300)
                        status_m = wdata;
                    else if (csr_addr == 12'h340)
                        scratch_m = wdata;
                end
            end
            if (reg_write_w && rd_w != 5'd0)
                shadow[rd_w] = result_w;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (cur_valid) begin
                check_value("valid_e", 32'd1, {31'd0, valid_e});
                check_value("pc_e", cur_pc, pc_e);
                check_value("pc_plus4_e", cur_pc + 32'd4, pc_plus4_e);
                check_value("rs1_e", {27'd0, cur_instr[19:15]}, {27'd0, rs1_e});
                check_value("rs2_e", {27'd0, cur_instr[24:20]}, {27'd0, rs2_e});
                check_value("rd_e", {27'd0, cur_instr[11:7]}, {27'd0, rd_e});
                check_value("imm_e", cur_imm, imm_e);
                check_value("alu_op_e", {28'd0, cur_alu}, {28'd0, alu_op_e});
                check_value("alu_src_e", {31'd0, cur_src}, {31'd0, alu_src_e});
                check_value("result_src_e", {30'd0, cur_res}, {30'd0, result_src_e});
                check_value("reg_write_e", {31'd0, cur_rw}, {31'd0, reg_write_e});
                check_value("mem_write_e", {31'd0, cur_mw}, {31'd0, mem_write_e});
                check_value("branch_e", {31'd0, cur_br}, {31'd0, branch_e});
                check_value("jump_e", {31'd0, cur_jp}, {31'd0, jump_e});
                check_value("illegal_e", {31'd0, cur_ill}, {31'd0, illegal_e});
                check_value("rd1_e", exp_rd1, rd1_e);
                check_value("rd2_e", exp_rd2, rd2_e);
                if (cur_csr)
                    check_value("csr_rdata_e", exp_csr, csr_rdata_e);
            end else begin
                // A bubble carries no enables into execute
                check_value("valid_e", 32'd0, {31'd0, valid_e});
                check_value("reg_write_e", 32'd0, {31'd0, reg_write_e});
                check_value("mem_write_e", 32'd0, {31'd0, mem_write_e});
                check_value("branch_e", 32'd0, {31'd0, branch_e});
                check_value("jump_e", 32'd0, {31'd0, jump_e});
                check_value("illegal_e", 32'd0, {31'd0, illegal_e});
            end
            check_value("status", status_m, status);
        end
    end

endmodule

//--- verification/decode_asserts.sv
`timescale 1ns/1ps

module decode_asserts (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        valid_e,
    input logic        reg_write_e,
    input logic        mem_write_e,
    input logic        branch_e,
    input logic        jump_e,
    input logic        illegal_e,
    input logic [31:0] pc_e,
    input logic [31:0] imm_e,
    input logic [31:0] rd1_e,
    input logic [31:0] status
);
    int fail_count = 0;

    reset_clears: assert property (@(posedge clk) reset |=> !valid_e && !reg_write_e
        && !mem_write_e && !branch_e && !jump_e && !illegal_e)
        else begin
            fail_count++;
            $error("ID/EX control not cleared after reset");
        end

    stall_holds: assert property (@(posedge clk) disable iff (reset) stall |=> $stable(valid_e)
        && $stable(pc_e) && $stable(imm_e) && $stable(rd1_e) && $stable(status))
        else begin
            fail_count++;
            $error("ID/EX outputs or status changed under stall");
        end

    illegal_no_write: assert property (@(posedge clk) illegal_e |-> !reg_write_e && !mem_write_e)
        else begin
            fail_count++;
            $error("Illegal instruction carries a write enable");
        end

endmodule

bind instr_decode decode_asserts u_asserts (.*);

//--- verification/decode_tb.sv
`timescale 1ns/1ps

module decode_tb import decode_pkg::*; ;
    typedef struct {
        string       name;
        logic [31:0] instr;
        logic [4:0]  wb_rd;
        logic        wb_we;
        logic        stall;
        logic        valid;
        logic [31:0] imm;
        alu_op_t     alu;
        logic        src;
        result_src_t res;
        logic        rw;
        logic        mw;
        logic        br;
        logic        jp;
        logic        ill;
    } row_t;

    logic        clk, reset, stall, instr_valid, reg_write_w;
    logic [31:0] instr, pc, result_w, pc_e, pc_plus4_e, rd1_e, rd2_e, imm_e, csr_rdata_e, status;
    logic [4:0]  rd_w, rs1_e, rs2_e, rd_e;
    logic        valid_e, alu_src_e, reg_write_e, mem_write_e, branch_e, jump_e, illegal_e;
    alu_op_t     alu_op_e;
    result_src_t result_src_e;
    int          errors;
    int          timeouts = 0;
    row_t        rows[$];

    instr_decode dut0 (.*);
    decode_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void add_row(input string name, input logic [31:0] ins, input logic [4:0] wr,
                                    input logic we, input logic st, input logic v,
                                    input logic [31:0] imm, input alu_op_t alu, input logic src,
                                    input result_src_t res, input logic rw, input logic mw,
                                    input logic br, input logic jp, input logic ill);
        rows.push_back('{name, ins, wr, we, st, v, imm, alu, src, res, rw, mw, br, jp, ill});
    endfunction

    task automatic apply_row(input row_t r);
        instr       = r.instr;
        instr_valid = r.valid;
        stall       = r.stall;
        pc          = $urandom & ~32'h3;
        rd_w        = r.wb_rd;
        reg_write_w = r.wb_we;
        result_w    = $urandom;
        chk0.set_expect(r.name, r.imm, r.alu, r.src, r.res, r.rw, r.mw, r.br, r.jp, r.ill);
    endtask

    task automatic wait_for_valid(input string name, input logic want);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 4 && !seen; n++) begin
            @(negedge clk);
            seen = (valid_e == want);
        end
        if (!seen) begin
            timeouts++;
            $display("Timed out waiting for valid_e to become %0b after row %s", want, name);
        end
    endtask

    initial begin
        void'($urandom(32'h7d1b));
        reset       = 1'b1;
        stall       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'h0000_0013;
        pc          = 32'd0;
        rd_w        = 5'd0;
        result_w    = 32'd0;
        reg_write_w = 1'b0;

        //      name           instr         wb_rd we stall v  imm           alu
        //      src res           rw mw br jp ill
        add_row("wb_x1",       32'h00000013, 5'd1, 1, 0, 1, 32'h00000000, alu_add,
                1, res_alu,      1, 0, 0, 0, 0);
        add_row("addi_neg",    32'hFFB08113, 5'd2, 1, 0, 1, 32'hFFFFFFFB, alu_add,
                1, res_alu,      1, 0, 0, 0, 0);
        add_row("add_bypass",  32'h002081B3, 5'd2, 1, 0, 1, 32'h00000002, alu_add,
                0, res_alu,      1, 0, 0, 0, 0);
        add_row("sub",         32'h40110233, 5'd4, 1, 0, 1, 32'h00000401, alu_sub,
                0, res_alu,      1, 0, 0, 0, 0);
        add_row("sra",         32'h4020D2B3, 5'd0, 0, 0, 1, 32'h00000402, alu_sra,
                0, res_alu,      1, 0, 0, 0, 0);
        add_row("srl",         32'h0020D2B3, 5'd0, 0, 0, 1, 32'h00000002, alu_srl,
                0, res_alu,      1, 0, 0, 0, 0);
        add_row("srai",        32'h4030D313, 5'd5, 1, 0, 1, 32'h00000403, alu_sra,
                1, res_alu,      1, 0, 0, 0, 0);
        add_row("addi_f7",     32'h40008393, 5'd0, 0, 0, 1, 32'h00000400, alu_add,
                1, res_alu,      1, 0, 0, 0, 0);
        add_row("store",       32'hFE20AC23, 5'd0, 0, 0, 1, 32'hFFFFFFF8, alu_add,
                1, res_alu,      0, 1, 0, 0, 0);
        add_row("branch",      32'hFE208863, 5'd0, 0, 0, 1, 32'hFFFFF7F0, alu_sub,
                0, res_alu,      0, 0, 1, 0, 0);
        add_row("lui",         32'h80001437, 5'd0, 0, 0, 1, 32'h80001000, alu_add,
                1, res_alu,      1, 0, 0, 0, 0);
        add_row("jal_pos",     32'h0010006F, 5'd0, 0, 0, 1, 32'h00000800, alu_add,
                0, res_pc_plus4, 1, 0, 0, 1, 0);
        add_row("jal_neg",     32'hFFDFF06F, 5'd0, 0, 0, 1, 32'hFFFFFFFC, alu_add,
                0, res_pc_plus4, 1, 0, 0, 1, 0);
        add_row("csrrw_scr",   32'h34009473, 5'd0, 0, 0, 1, 32'h00000340, alu_add,
                0, res_csr,      1, 0, 0, 0, 0);
        add_row("csrrw_scr2",  32'h34011573, 5'd0, 0, 0, 1, 32'h00000340, alu_add,
                0, res_csr,      1, 0, 0, 0, 0);
        add_row("csrrwi_st",   32'h300AD073, 5'd0, 0, 0, 1, 32'h00000300, alu_add,
                0, res_csr,      1, 0, 0, 0, 0);
        add_row("stall_held",  32'h3003D073, 5'd7, 1, 1, 1, 32'h00000300, alu_add,
                0, res_csr,      1, 0, 0, 0, 0);
        add_row("csrrwi_rel",  32'h3003D073, 5'd0, 0, 0, 1, 32'h00000300, alu_add,
                0, res_csr,      1, 0, 0, 0, 0);
        add_row("illegal_opc", 32'h0000007F, 5'd0, 0, 0, 1, 32'h00000000, alu_add,
                0, res_alu,      0, 0, 0, 0, 1);
        add_row("illegal_sys", 32'h00000073, 5'd0, 0, 0, 1, 32'h00000000, alu_add,
                0, res_alu,      0, 0, 0, 0, 1);
        add_row("x0_write",    32'h000005B3, 5'd0, 1, 0, 1, 32'h00000000, alu_add,
                0, res_alu,      1, 0, 0, 0, 0);
        add_row("bubble",      32'h00000013, 5'd6, 1, 0, 0, 32'h00000000, alu_add,
                1, res_alu,      0, 0, 0, 0, 0);
        add_row("after_bub",   32'h00030333, 5'd0, 0, 0, 1, 32'h00000000, alu_add,
                0, res_alu,      1, 0, 0, 0, 0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            apply_row(rows[i]);
            wait_for_valid(rows[i].name, rows[i].valid);
        end
        instr_valid = 1'b0;
        reg_write_w = 1'b0;
        stall       = 1'b0;
        wait_for_valid("drain", 1'b0);

        $display("Check summary: %0d value errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut0.u_asserts.fail_count);
        if (errors == 0 && timeouts == 0 && dut0.u_asserts.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Bounds the whole run in case the table loop stops advancing
    initial begin
        repeat (400) @(posedge clk);
        $display("Simulation limit reached before the table finished");
        $display("Errors found");
        $finish;
    end

endmodule

//--- vlog.f
logic/decode_pkg.sv
logic/control_unit.sv
logic/imm_extend.sv
logic/reg_file.sv
logic/csr_file.sv
logic/instr_decode.sv
verification/decode_checker.sv
verification/decode_asserts.sv
verification/decode_tb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module decode_tb

sim:
	verilator --binary --timing --assert -f vlog.f --top-module decode_tb -o decode_sim
	./obj_dir/decode_sim | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
